/* Makefile */
TOP := tb_pcm_sound

all: run

build:
	verilator --binary --timing -f files.f --top-module $(TOP) -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "^test passed$$"

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* common/pcm_params.svh */
// size and rate constants of the pcm sound block, included by rtl and testbench
`ifndef PCM_PARAMS_SVH
`define PCM_PARAMS_SVH

// number of voices, a power of two
`define PCM_NUM_VOICES 8

// sample rom address width, 3 bank bits plus 16 address bits
`define PCM_ROM_AW 19

// cen pulses per sequencer step
`define PCM_CEN_PER_STEP 2

// one frame visits every voice for 16 steps
`define PCM_STEPS_PER_FRAME (16 * `PCM_NUM_VOICES)

`endif

/* common/pcm_pkg.sv */
// shared types for the pcm sound block, referenced by scoped name from rtl and testbench
package pcm_pkg;

    // sixteen steps of one voice slot, one step per sequencer tick
    typedef enum logic [3:0] {
        rd_enable   = 4'd0,
        rd_addr_lo  = 4'd1,
        rd_addr_mid = 4'd2,
        rd_addr_hi  = 4'd3,
        rd_delta    = 4'd4,
        rd_loop_mid = 4'd5,
        rd_loop_hi  = 4'd6,
        rd_end      = 4'd7,
        wr_enable   = 4'd8,  // rom fetch issued here
        wr_addr_lo  = 4'd9,
        wr_addr_mid = 4'd10,
        wr_addr_hi  = 4'd11,
        rd_vol_l    = 4'd12,
        rd_vol_r    = 4'd13, // rom data sampled
        latch_r     = 4'd14,
        accumulate  = 4'd15
    } seq_step_e;

    // byte offsets inside one voice's register block
    typedef enum logic [3:0] {
        vol_l    = 4'd2,
        vol_r    = 4'd3,
        loop_mid = 4'd4,
        loop_hi  = 4'd5,
        end_hi   = 4'd6,
        delta    = 4'd7,
        addr_lo  = 4'd11, // fractional part
        addr_mid = 4'd12,
        addr_hi  = 4'd13,
        enable   = 4'd14  // bit 0 mute, bit 1 one-shot, bits 6..4 bank
    } voice_reg_e;

endpackage

/* common/voice_cfg_if.sv */
// voice register port between the step sequencer and the register ram
`timescale 1ns/100ps
`include "pcm_params.svh"

interface voice_cfg_if;

    logic [$clog2(`PCM_NUM_VOICES)-1:0] voice;  // voice being served
    logic [3:0]                         offset; // register within the voice
    logic [7:0]                         wdata;
    logic                               we;
    logic [7:0]                         rdata;  // valid one clock after address

    modport seq (
        output voice,
        output offset,
        output wdata,
        output we,
        input  rdata
    );

    modport ram (
        input  voice,
        input  offset,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

/* files.f */
+incdir+common
+incdir+verif
common/pcm_pkg.sv
common/voice_cfg_if.sv
src/pcm_step_timer.sv
pcm_core/pcm_voice_seq.sv
pcm_core/pcm_addr_step.sv
pcm_core/pcm_mixer.sv
pcm_core/pcm_reg_ram.sv
src/pcm_sound_top.sv
verif/tb_pcm_sound.sv

/* pcm_core/pcm_addr_step.sv */
// per-voice play address: collects the register bytes, applies end and loop, advances by delta
`timescale 1ns/100ps
`include "pcm_params.svh"

module pcm_addr_step (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   step_tick,
    input  pcm_pkg::seq_step_e     step,
    input  logic [7:0]             rdata,
    output logic [7:0]             wb_data,
    output logic [`PCM_ROM_AW-1:0] rom_addr,
    output logic                   mute
);

    logic [7:0]  en_q;      // enable byte of the current voice
    logic [23:0] cur_addr;  // 16.8 play address
    logic [15:0] loop_addr;
    logic [7:0]  delta;
    logic        end_hit;

    assign end_hit = (cur_addr[23:16] == rdata);
    assign mute    = en_q[0];

    always_comb begin
        case (step)
            pcm_pkg::wr_enable:   wb_data = en_q;
            pcm_pkg::wr_addr_lo:  wb_data = cur_addr[7:0];
            pcm_pkg::wr_addr_mid: wb_data = cur_addr[15:8];
            default:              wb_data = cur_addr[23:16];
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            en_q     <= '0;
            rom_addr <= '0;
        end else if (step_tick) begin
            case (step)
                pcm_pkg::rd_enable: en_q <= rdata;
                pcm_pkg::rd_end: begin
                    if (end_hit && en_q[1]) begin
                        en_q[0] <= 1'b1; // one-shot finished
                    end
                end
                pcm_pkg::wr_enable: rom_addr <= {en_q[6:4], cur_addr[23:8]};
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (step_tick) begin
            case (step)
                pcm_pkg::rd_addr_lo:  cur_addr[7:0]    <= rdata;
                pcm_pkg::rd_addr_mid: cur_addr[15:8]   <= rdata;
                pcm_pkg::rd_addr_hi:  cur_addr[23:16]  <= rdata;
                pcm_pkg::rd_delta:    delta            <= rdata;
                pcm_pkg::rd_loop_mid: loop_addr[7:0]   <= rdata;
                pcm_pkg::rd_loop_hi:  loop_addr[15:8]  <= rdata;
                pcm_pkg::rd_end: begin
                    if (end_hit) begin
                        if (en_q[1]) begin
                            cur_addr[7:0] <= '0;
                        end else begin
                            cur_addr <= {loop_addr, 8'd0}; // loop around
                        end
                    end
                end
                pcm_pkg::wr_enable:   cur_addr <= cur_addr + {16'd0, delta};
                default: ;
            endcase
        end
    end

endmodule

/* pcm_core/pcm_mixer.sv */
// volume scaling and saturating stereo mix of all voices, latched out once per frame
`timescale 1ns/100ps

module pcm_mixer (
    input  logic                clk,
    input  logic                rst,
    input  logic                step_tick,
    input  logic                frame_start,
    input  logic                mute,
    input  logic                rom_ok,
    input  pcm_pkg::seq_step_e  step,
    input  logic [7:0]          rdata,
    input  logic [7:0]          rom_data,
    output logic signed [15:0]  snd_left,
    output logic signed [15:0]  snd_right,
    output logic                sample
);

    logic [6:0]         vol_l_q;
    logic [6:0]         vol_r_q;
    logic signed [7:0]  smp;      // signed sample, zero if rom was late
    logic signed [7:0]  vol_sel;
    logic signed [15:0] mul;
    logic signed [15:0] prod_r;
    logic signed [15:0] acc_l;
    logic signed [15:0] acc_r;

    function automatic logic signed [15:0] sat_add(input logic signed [15:0] a,
                                                   input logic signed [15:0] b);
        logic signed [16:0] full;
        full = {a[15], a} + {b[15], b};
        if (full[16] == full[15]) begin
            return full[15:0];
        end
        return full[16] ? 16'sh8000 : 16'sh7fff;
    endfunction

    // right volume while latch_r runs, left otherwise
    assign vol_sel = (step == pcm_pkg::latch_r) ? {1'b0, vol_r_q} : {1'b0, vol_l_q};

    always_ff @(posedge clk) begin
        mul <= vol_sel * smp; // one clock behind the volume select
        if (step_tick) begin
            case (step)
                pcm_pkg::rd_vol_l: vol_l_q <= rdata[6:0];
                pcm_pkg::rd_vol_r: begin
                    vol_r_q <= rdata[6:0];
                    smp     <= rom_ok ? signed'(rom_data - 8'h80) : 8'sd0;
                end
                pcm_pkg::latch_r:  prod_r <= mul;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc_l     <= '0;
            acc_r     <= '0;
            snd_left  <= '0;
            snd_right <= '0;
            sample    <= 1'b0;
        end else begin
            sample <= step_tick && frame_start;
            if (step_tick && frame_start) begin
                snd_left  <= acc_l;
                snd_right <= acc_r;
                acc_l     <= '0;
                acc_r     <= '0;
            end else if (step_tick && step == pcm_pkg::accumulate && !mute) begin
                acc_l <= sat_add(acc_l, mul);
                acc_r <= sat_add(acc_r, prod_r);
            end
        end
    end

endmodule

/* pcm_core/pcm_reg_ram.sv */
// voice register memory with a cpu port and a sequencer port, both with registered reads
`timescale 1ns/100ps
`include "pcm_params.svh"

module pcm_reg_ram (
    input  logic        clk,
    input  logic [7:0]  cpu_addr,
    input  logic [7:0]  cpu_wdata,
    input  logic        cpu_we,
    output logic [7:0]  cpu_rdata,
    voice_cfg_if.ram    cfg
);

    localparam int DEPTH = 16 * `PCM_NUM_VOICES;
    localparam int AW    = $clog2(DEPTH);

    logic [7:0]    mem [0:DEPTH-1];
    logic [AW-1:0] cpu_a;
    logic [AW-1:0] seq_a;

    // bit 7 picks the upper register half, bits 5..3 the voice
    assign cpu_a = {cpu_addr[7], cpu_addr[5:0]};
    assign seq_a = {cfg.offset[3], cfg.voice, cfg.offset[2:0]};

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_a] <= cpu_wdata;
        end
        if (cfg.we) begin
            mem[seq_a] <= cfg.wdata; // sequencer wins on a collision
        end
        cpu_rdata <= mem[cpu_a];
        cfg.rdata <= mem[seq_a];
    end

endmodule

/* pcm_core/pcm_voice_seq.sv */
// step sequencer that walks each voice slot, steering register reads, write-backs and rom fetch
`timescale 1ns/100ps
`include "pcm_params.svh"

module pcm_voice_seq (
    input  logic                clk,
    input  logic                rst,
    input  logic                step_tick,
    voice_cfg_if.seq            cfg,
    input  logic [7:0]          wb_data,
    output pcm_pkg::seq_step_e  step,
    output logic                frame_start,
    output logic                rom_cs
);

    localparam int VW = $clog2(`PCM_NUM_VOICES);

    logic [VW-1:0]        voice;
    logic                 primed;   // first pass through voice 0 is not a frame end
    logic                 wb_step;
    pcm_pkg::voice_reg_e  offset;

    // register addressed by each step
    always_comb begin
        case (step)
            pcm_pkg::rd_enable,
            pcm_pkg::wr_enable:   offset = pcm_pkg::enable;
            pcm_pkg::rd_addr_lo,
            pcm_pkg::wr_addr_lo:  offset = pcm_pkg::addr_lo;
            pcm_pkg::rd_addr_mid,
            pcm_pkg::wr_addr_mid: offset = pcm_pkg::addr_mid;
            pcm_pkg::rd_addr_hi,
            pcm_pkg::wr_addr_hi:  offset = pcm_pkg::addr_hi;
            pcm_pkg::rd_delta:    offset = pcm_pkg::delta;
            pcm_pkg::rd_loop_mid: offset = pcm_pkg::loop_mid;
            pcm_pkg::rd_loop_hi:  offset = pcm_pkg::loop_hi;
            pcm_pkg::rd_end:      offset = pcm_pkg::end_hi;
            pcm_pkg::rd_vol_l:    offset = pcm_pkg::vol_l;
            pcm_pkg::rd_vol_r:    offset = pcm_pkg::vol_r;
            default:              offset = pcm_pkg::enable; // read is ignored
        endcase
    end

    assign wb_step = (step == pcm_pkg::wr_enable)   ||
                     (step == pcm_pkg::wr_addr_lo)  ||
                     (step == pcm_pkg::wr_addr_mid) ||
                     (step == pcm_pkg::wr_addr_hi);

    assign cfg.voice  = voice;
    assign cfg.offset = offset;
    assign cfg.wdata  = wb_data;
    assign cfg.we     = wb_step && step_tick; // one write at the end of each write-back step

    assign frame_start = primed && (voice == '0) && (step == pcm_pkg::rd_enable);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step   <= pcm_pkg::rd_enable;
            voice  <= '0;
            rom_cs <= 1'b0;
            primed <= 1'b0;
        end else if (step_tick) begin
            step   <= pcm_pkg::seq_step_e'(step + 4'd1);
            primed <= 1'b1;
            if (step == pcm_pkg::accumulate) begin
                voice <= voice + 1'b1; // next slot
            end
            if (step == pcm_pkg::wr_enable) begin
                rom_cs <= 1'b1;        // address goes out now
            end else if (step == pcm_pkg::latch_r) begin
                rom_cs <= 1'b0;
            end
        end
    end

endmodule

/* src/pcm_sound_top.sv */
// top of the eight-voice pcm playback block, plain cpu, rom and audio ports
`timescale 1ns/100ps
`include "pcm_params.svh"

module pcm_sound_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic                   cpu_cs,
    input  logic                   cpu_rnw,
    input  logic [7:0]             cpu_addr,
    input  logic [7:0]             cpu_wdata,
    output logic [7:0]             cpu_rdata,
    output logic [`PCM_ROM_AW-1:0] rom_addr,
    input  logic [7:0]             rom_data,
    input  logic                   rom_ok,
    output logic                   rom_cs,
    output logic signed [15:0]     snd_left,
    output logic signed [15:0]     snd_right,
    output logic                   sample
);

    pcm_pkg::seq_step_e step;
    logic               step_tick;
    logic               frame_start;
    logic               mute;
    logic [7:0]         wb_data;
    logic               cpu_we;

    voice_cfg_if cfg_bus ();

    assign cpu_we = cpu_cs && !cpu_rnw; // no wait states

    pcm_step_timer i_timer (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .step_tick (step_tick)
    );

    pcm_voice_seq i_seq (
        .clk         (clk),
        .rst         (rst),
        .step_tick   (step_tick),
        .cfg         (cfg_bus.seq),
        .wb_data     (wb_data),
        .step        (step),
        .frame_start (frame_start),
        .rom_cs      (rom_cs)
    );

    pcm_addr_step i_addr (
        .clk       (clk),
        .rst       (rst),
        .step_tick (step_tick),
        .step      (step),
        .rdata     (cfg_bus.rdata),
        .wb_data   (wb_data),
        .rom_addr  (rom_addr),
        .mute      (mute)
    );

    pcm_mixer i_mixer (
        .clk         (clk),
        .rst         (rst),
        .step_tick   (step_tick),
        .frame_start (frame_start),
        .mute        (mute),
        .rom_ok      (rom_ok),
        .step        (step),
        .rdata       (cfg_bus.rdata),
        .rom_data    (rom_data),
        .snd_left    (snd_left),
        .snd_right   (snd_right),
        .sample      (sample)
    );

    pcm_reg_ram i_ram (
        .clk       (clk),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_we    (cpu_we),
        .cpu_rdata (cpu_rdata),
        .cfg       (cfg_bus.ram)
    );

endmodule

/* src/pcm_step_timer.sv */
// turns the cen pulses into sequencer step ticks, one per PCM_CEN_PER_STEP pulses
`timescale 1ns/100ps
`include "pcm_params.svh"

module pcm_step_timer (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    output logic step_tick
);

    localparam int CW = (`PCM_CEN_PER_STEP > 2) ? $clog2(`PCM_CEN_PER_STEP) : 1;
    localparam logic [CW-1:0] LAST = CW'(`PCM_CEN_PER_STEP - 1);

    logic [CW-1:0] cen_cnt;

    // tick on the last cen of each group
    assign step_tick = cen && (cen_cnt == LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_cnt <= '0;
        end else if (cen) begin
            if (cen_cnt == LAST) begin
                cen_cnt <= '0; // wrap
            end else begin
                cen_cnt <= cen_cnt + 1'b1;
            end
        end
    end

endmodule

/* verif/pcm_ref_model.svh */
// reference model of the pcm block, included inside the testbench module for expected values
`ifndef PCM_REF_MODEL_SVH
`define PCM_REF_MODEL_SVH

logic [7:0] shadow [0:`PCM_NUM_VOICES-1][0:15]; // image of every voice register
logic [`PCM_ROM_AW-1:0] exp_rom_addr [0:`PCM_NUM_VOICES-1]; // fetch address of each voice

// sample rom contents, low byte xor middle byte
function automatic logic [7:0] rom_byte(input logic [`PCM_ROM_AW-1:0] addr);
    return addr[7:0] ^ addr[15:8];
endfunction

function automatic int clamp16(input int value);
    if (value > 32767) begin
        return 32767;
    end
    if (value < -32768) begin
        return -32768;
    end
    return value;
endfunction

// one frame of all voices, updating the shadow registers as the write-back does
task automatic model_frame(input logic [7:0] ok_mask, output logic [15:0] exp_l,
                           output logic [15:0] exp_r);
    logic [7:0]             en;
    logic [23:0]            a;
    logic [`PCM_ROM_AW-1:0] raddr;
    int                     s;
    int                     acc_l;
    int                     acc_r;
    int                     v;
    acc_l = 0;
    acc_r = 0;
    for (v = 0; v < `PCM_NUM_VOICES; v++) begin
        en = shadow[v][pcm_pkg::enable];
        a  = {shadow[v][pcm_pkg::addr_hi], shadow[v][pcm_pkg::addr_mid],
              shadow[v][pcm_pkg::addr_lo]};
        if (a[23:16] == shadow[v][pcm_pkg::end_hi]) begin
            if (en[1]) begin
                en[0]   = 1'b1; // one-shot stops
                a[7:0]  = 8'h00;
            end else begin
                a = {shadow[v][pcm_pkg::loop_hi], shadow[v][pcm_pkg::loop_mid], 8'h00};
            end
        end
        raddr = {en[6:4], a[23:8]};
        exp_rom_addr[v] = raddr;
        a     = a + {16'h0000, shadow[v][pcm_pkg::delta]};
        shadow[v][pcm_pkg::enable]   = en;
        shadow[v][pcm_pkg::addr_lo]  = a[7:0];
        shadow[v][pcm_pkg::addr_mid] = a[15:8];
        shadow[v][pcm_pkg::addr_hi]  = a[23:16];
        s = ok_mask[v] ? int'(rom_byte(raddr)) - 128 : 0; // late rom gives silence
        if (!en[0]) begin
            acc_l = clamp16(acc_l + s * int'(shadow[v][pcm_pkg::vol_l][6:0]));
            acc_r = clamp16(acc_r + s * int'(shadow[v][pcm_pkg::vol_r][6:0]));
        end
    end
    exp_l = acc_l[15:0];
    exp_r = acc_r[15:0];
endtask

`endif

/* verif/tb_pcm_sound.sv */
// testbench for the pcm sound block, run as top with lfsr stimulus and a reference model
`timescale 1ns/100ps
`include "pcm_params.svh"

module tb_pcm_sound;

    localparam int FRAME_CLKS   = `PCM_STEPS_PER_FRAME * `PCM_CEN_PER_STEP;
    localparam int TOTAL_FRAMES = 18;

    logic                   clk;
    logic                   rst;
    logic                   cen;
    logic                   cpu_cs;
    logic                   cpu_rnw;
    logic [7:0]             cpu_addr;
    logic [7:0]             cpu_wdata;
    logic [7:0]             cpu_rdata;
    logic [`PCM_ROM_AW-1:0] rom_addr;
    logic [7:0]             rom_data = 8'h00;
    logic                   rom_ok = 1'b0;
    logic                   rom_cs;
    logic signed [15:0]     snd_left;
    logic signed [15:0]     snd_right;
    logic                   sample;

    logic [31:0] lfsr_state = 32'd84447;
    logic [7:0]  ok_mask = 8'hff; // rom_ok per voice for the current frame
    logic [2:0]  rom_voice;       // voice owning the current rom fetch
    logic        cs_seen;

    `include "pcm_ref_model.svh"

    pcm_sound_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .cpu_cs    (cpu_cs),
        .cpu_rnw   (cpu_rnw),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .rom_cs    (rom_cs),
        .snd_left  (snd_left),
        .snd_right (snd_right),
        .sample    (sample)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // rom model answers on the falling edge and counts voices by rom_cs falls
    always @(negedge clk) begin
        if (rst) begin
            rom_voice = 3'd0;
        end else if (cs_seen && !rom_cs) begin
            rom_voice = rom_voice + 3'd1;
        end
        if (!rst && rom_cs && !cs_seen) begin
            check_value("rom_addr", 32'(rom_addr), 32'(exp_rom_addr[rom_voice])); // new fetch
        end
        cs_seen = rom_cs && !rst;
        rom_data <= rom_cs ? rom_byte(rom_addr) : 8'h00;
        rom_ok   <= rom_cs && ok_mask[rom_voice];
    end

    initial begin
        #((TOTAL_FRAMES * FRAME_CLKS + 4000) * 20);
        $display("sample strobes stopped before all frames were checked");
        $display("test failed");
        $fatal(1, "watchdog timeout");
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] val);
        int i;
        val = 8'h00;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[6:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("test failed");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic logic [7:0] cpu_map(input int v, input int o);
        return {o[3], 1'b0, v[2:0], o[2:0]};
    endfunction

    task automatic cpu_write(input logic [7:0] addr, input logic [7:0] data);
        @(negedge clk);
        cpu_cs    = 1'b1;
        cpu_rnw   = 1'b0;
        cpu_addr  = addr;
        cpu_wdata = data;
    endtask

    task automatic cpu_read(input logic [7:0] addr, output logic [7:0] data);
        @(negedge clk);
        cpu_cs   = 1'b1;
        cpu_rnw  = 1'b1;
        cpu_addr = addr;
        @(negedge clk);
        data   = cpu_rdata; // registered one clock after the address
        cpu_cs = 1'b0;
    endtask

    task automatic set_reg(input int v, input int o, input logic [7:0] val);
        cpu_write(cpu_map(v, o), val);
        shadow[v][o] = val;
    endtask

    // hold the block in reset and give every register a random value
    task automatic setup_random();
        logic [7:0] b;
        int         v;
        int         o;
        @(negedge clk);
        rst = 1'b1;
        for (v = 0; v < `PCM_NUM_VOICES; v++) begin
            for (o = 0; o < 16; o++) begin
                take_bits(8, b);
                set_reg(v, o, b);
            end
        end
    endtask

    // address one carry below end_hi so the end is reached in the second frame
    task automatic aim_at_end(input int v, input logic [7:0] en);
        logic [7:0] b;
        take_bits(8, b);
        set_reg(v, pcm_pkg::end_hi, b);
        set_reg(v, pcm_pkg::addr_hi, b - 8'd1);
        set_reg(v, pcm_pkg::addr_mid, 8'hff);
        take_bits(7, b);
        set_reg(v, pcm_pkg::addr_lo, {1'b1, b[6:0]});
        take_bits(7, b);
        set_reg(v, pcm_pkg::delta, {1'b1, b[6:0]});
        take_bits(5, b);
        set_reg(v, pcm_pkg::vol_l, b);
        take_bits(5, b);
        set_reg(v, pcm_pkg::vol_r, b);
        set_reg(v, pcm_pkg::enable, en);
    endtask

    task automatic wait_sample(input bit check_period);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!sample);
        if (check_period) begin
            check_value("sample period", n, FRAME_CLKS);
        end
    endtask

    // release reset and check each frame against the model
    task automatic run_frames(input int n, input bit random_ok);
        logic [15:0] exp_l;
        logic [15:0] exp_r;
        logic [7:0]  m;
        int          f;
        @(negedge clk);
        cpu_cs = 1'b0;
        rst    = 1'b0;
        m = 8'hff;
        if (random_ok) begin
            take_bits(8, m);
        end
        ok_mask = m;
        model_frame(ok_mask, exp_l, exp_r);
        for (f = 0; f < n; f++) begin
            wait_sample(f != 0);
            check_value("snd_left", {16'h0000, snd_left}, {16'h0000, exp_l});
            check_value("snd_right", {16'h0000, snd_right}, {16'h0000, exp_r});
            if (random_ok) begin
                take_bits(8, m);
            end
            ok_mask = m;
            model_frame(ok_mask, exp_l, exp_r);
        end
    endtask

    initial begin
        logic [7:0] d;
        logic [7:0] r;
        logic [7:0] b;
        int         v;
        int         o;
        rst       = 1'b1;
        cen       = 1'b1;
        cpu_cs    = 1'b0;
        cpu_rnw   = 1'b1;
        cpu_addr  = 8'h00;
        cpu_wdata = 8'h00;
        repeat (16) @(negedge clk);

        setup_random(); // register readback
        for (v = 0; v < `PCM_NUM_VOICES; v++) begin
            for (o = 0; o < 16; o++) begin
                cpu_read(cpu_map(v, o), d);
                check_value("cpu_rdata", d, shadow[v][o]);
            end
        end

        setup_random(); // one looping voice, others muted
        for (v = 1; v < `PCM_NUM_VOICES; v++) begin
            set_reg(v, pcm_pkg::enable, shadow[v][pcm_pkg::enable] | 8'h01);
        end
        take_bits(3, b);
        aim_at_end(0, {1'b0, b[2:0], 4'h0});
        run_frames(6, 1'b0);

        setup_random(); // one-shot voice
        take_bits(3, b);
        aim_at_end(0, {1'b0, b[2:0], 4'h2});
        run_frames(4, 1'b0);
        cpu_read(cpu_map(0, pcm_pkg::enable), d);
        check_value("enable", d, shadow[0][pcm_pkg::enable]);
        check_value("enable bit 0", d[0], 1);

        setup_random(); // all voices at full volume, same extreme sample
        take_bits(1, b);
        for (v = 0; v < `PCM_NUM_VOICES; v++) begin
            take_bits(8, r);
            set_reg(v, pcm_pkg::addr_hi, r);
            set_reg(v, pcm_pkg::addr_mid, b[0] ? r : ~r); // rom byte 0x00 or 0xff
            set_reg(v, pcm_pkg::end_hi, r ^ 8'h80);
            set_reg(v, pcm_pkg::delta, 8'h00);
            set_reg(v, pcm_pkg::vol_l, 8'h7f);
            set_reg(v, pcm_pkg::vol_r, 8'h7f);
            set_reg(v, pcm_pkg::enable, shadow[v][pcm_pkg::enable] & 8'h70);
        end
        run_frames(3, 1'b0);

        setup_random(); // random rom_ok per frame
        for (v = 0; v < `PCM_NUM_VOICES; v++) begin
            set_reg(v, pcm_pkg::enable, shadow[v][pcm_pkg::enable] & 8'h70);
        end
        run_frames(5, 1'b1);

        $display("test passed");
        $finish;
    end

endmodule
